// File: all.f
+incdir+rtl
rtl/rtg_pkg.sv
rtl/rtg_config_regs.sv
rtl/rtg_clut_ram.sv
rtl/rtg_blank_gen.sv
rtl/rtg_fetch_timing.sv
rtl/rtg_pixel_out.sv
rtl/rtg_video_top.sv
sim/rtg_video_properties.sv
sim/rtg_video_checker.sv
sim/tb_rtg_video.sv

// File: rtl/rtg_blank_gen.sv
/*
  RTG blanking. Hides the first vbend lines after chipset vblank,
  counted on hsync rising edges, and merges in hblank.
*/
`timescale 1ns/1ps
`include "rtg_defines.svh"

module rtg_blank_gen (
  input  logic                    clk_114,
  input  logic                    arst_n,
  input  logic                    vblank,
  input  logic                    hblank,
  input  logic                    chip_hsync,
  input  logic [`RTG_VBEND_W-1:0] vbend,
  output logic                    rtg_blank,
  output logic                    rtg_blank_d
);

  logic                    hsync_d;     // previous hsync sample
  logic                    hsync_rise;  // one clock per line
  logic                    rtg_vblank;  // top of frame still hidden
  logic [`RTG_VBEND_W-1:0] vb_cnt;      // lines since vblank fell

  assign hsync_rise = chip_hsync & ~hsync_d;

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      hsync_d    <= 1'b0;
      rtg_vblank <= 1'b1;  // hidden until the first frame
      vb_cnt     <= '0;
      rtg_blank_d <= 1'b1;
    end else begin
      hsync_d     <= chip_hsync;
      rtg_blank_d <= rtg_blank;
      if (vblank) begin               // frame start, restart the count
        rtg_vblank <= 1'b1;
        vb_cnt     <= '0;
      end else if (vb_cnt == vbend) begin
        rtg_vblank <= 1'b0;           // reached the visible area
      end else if (hsync_rise) begin
        vb_cnt <= vb_cnt + 1'b1;
      end
    end
  end

  assign rtg_blank = rtg_vblank | hblank;

endmodule

// File: rtl/rtg_clut_ram.sv
/*
  256-entry colour look-up table. Synchronous write from the config
  decoder, registered read of one cycle for the pixel path.
*/
`timescale 1ns/1ps
`include "rtg_defines.svh"

module rtg_clut_ram (
  input  logic                    clk_114,
  input  logic                    clut_we,
  input  logic [`RTG_CLUT_AW-1:0] clut_waddr,
  input  rtg_pkg::rgb_t           clut_wdata,
  input  logic [`RTG_CLUT_AW-1:0] clut_idx,
  output rtg_pkg::rgb_t           clut_rgb
);

  localparam int DEPTH = 1 << `RTG_CLUT_AW;

  rtg_pkg::rgb_t mem [DEPTH]; // undefined until written

  // write port
  always_ff @(posedge clk_114) begin
    if (clut_we) begin
      mem[clut_waddr] <= clut_wdata;
    end
  end

  // read port, one cycle
  always_ff @(posedge clk_114) begin
    clut_rgb <= mem[clut_idx];
  end

endmodule

// File: rtl/rtg_config_regs.sv
/*
  Configuration write decoder. One write per cycle of cfg_we loads
  the mode register or is passed on as a colour table write.
*/
`timescale 1ns/1ps
`include "rtg_defines.svh"

module rtg_config_regs (
  input  logic                    clk_114,
  input  logic                    arst_n,
  input  logic                    cfg_we,
  input  logic [`RTG_CFG_AW-1:0]  cfg_addr,
  input  logic [23:0]             cfg_wdata,
  output rtg_pkg::rtg_mode_t      mode,
  output logic                    clut_we,
  output logic [`RTG_CLUT_AW-1:0] clut_waddr,
  output rtg_pkg::rgb_t           clut_wdata
);

  localparam int MODE_W = $bits(rtg_pkg::rtg_mode_t);

  logic mode_hit; // write to the mode register
  logic clut_hit; // write inside the colour table window

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mode_hit = cfg_we && (cfg_addr == `RTG_ADDR_MODE);
    clut_hit = cfg_we && (cfg_addr >= `RTG_CLUT_BASE);
  end

  //////////////////////////////////////////////////////////////////////
  // mode register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      mode <= '0; // RTG off, chipset passes through
    end else if (mode_hit) begin
      mode <= rtg_pkg::rtg_mode_t'(cfg_wdata[MODE_W-1:0]);
    end
  end

  // colour table write goes straight to the RAM, visible next cycle
  // window base sits on a power of two, so the low bits are the entry
  assign clut_we    = clut_hit;
  assign clut_waddr = cfg_addr[`RTG_CLUT_AW-1:0];  // offset into window
  assign clut_wdata = rtg_pkg::rgb_t'(cfg_wdata);  // {r, g, b}

endmodule

// File: rtl/rtg_defines.svh
/*
  Widths and configuration addresses for the RTG display path.
  Include wherever a width or register address is needed.
*/
`ifndef RTG_DEFINES_SVH
`define RTG_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// data widths
//////////////////////////////////////////////////////////////////////

`define RTG_WORD_W    16   // one fetched pixel word
`define RTG_COLOR_W   8    // per colour channel
`define RTG_PWIDTH_W  4    // clocks per fetch, minus one
`define RTG_VBEND_W   7    // lines hidden after vblank
`define RTG_CLUT_AW   8    // 256 colour table entries

//////////////////////////////////////////////////////////////////////
// configuration address map
//////////////////////////////////////////////////////////////////////

`define RTG_CFG_AW    9    // 512 locations in all

// mode register; wdata[13:0] = {ena, clut, ext, pixelwidth, vbend}
`define RTG_ADDR_MODE 9'd0

// colour table window, 256..511; wdata = {r, g, b}
`define RTG_CLUT_BASE 9'd256

`endif

// File: rtl/rtg_fetch_timing.sv
/*
  Pixel clock counter for the RTG picture. Raises fetch_req once per
  pixelwidth+1 clocks while visible and picks the CLUT byte of a word.
*/
`timescale 1ns/1ps
`include "rtg_defines.svh"

module rtg_fetch_timing (
  input  logic               clk_114,
  input  logic               arst_n,
  input  rtg_pkg::rtg_mode_t mode,
  input  logic               rtg_blank,
  input  logic               rtg_blank_d,
  output logic               fetch_req,
  output logic               clut_sel_d
);

  logic [`RTG_PWIDTH_W-1:0] pix_cnt;  // compared against pixelwidth
  logic [`RTG_PWIDTH_W-1:0] half_cnt; // second byte point of a word
  logic                     fetch_ok; // visible, or the one extended clock
  logic                     clut_sel; // low byte is next

  assign half_cnt = mode.pixelwidth >> 1;

  // ext lets the fetch run one clock into blank
  assign fetch_ok  = !rtg_blank || (!rtg_blank_d && mode.ext);
  assign fetch_req = mode.ena && fetch_ok && (pix_cnt == mode.pixelwidth);

  //////////////////////////////////////////////////////////////////////
  // counter and byte select
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      pix_cnt    <= '0;
      clut_sel   <= 1'b0;
      clut_sel_d <= 1'b0;
    end else begin
      clut_sel_d <= clut_sel;
      if (rtg_blank || fetch_req) begin
        pix_cnt  <= '0;            // restart with each word
        clut_sel <= 1'b0;
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
        if (pix_cnt == half_cnt) begin
          clut_sel <= 1'b1;        // halfway, switch to the low byte
        end
      end
    end
  end

endmodule

// File: rtl/rtg_pixel_out.sv
/*
  Output pixel path. Expands RGB555 or looks up the CLUT, picks RTG or
  chipset colour, mixes in the OSD and registers the video outputs.
*/
`timescale 1ns/1ps
`include "rtg_defines.svh"

module rtg_pixel_out (
  input  logic                    clk_114,
  input  logic                    arst_n,
  input  rtg_pkg::rtg_mode_t      mode,
  input  logic                    rtg_blank,
  input  logic                    clut_sel_d,
  input  logic [`RTG_WORD_W-1:0]  rtg_data,
  input  rtg_pkg::rgb_t           chip_rgb,
  input  logic                    chip_hsync,
  input  logic                    chip_vsync,
  input  logic                    osd_window,
  input  logic                    osd_pixel,
  output logic [`RTG_CLUT_AW-1:0] clut_idx,
  input  rtg_pkg::rgb_t           clut_rgb,
  output rtg_pkg::rgb_t           vid_rgb,
  output logic                    vid_hsync,
  output logic                    vid_vsync
);

  localparam int CW = `RTG_COLOR_W;

  rtg_pkg::rgb_t hc_rgb, src_now, src_clut, chip_rgb_d, out_nxt;
  logic          rtg_on, rtg_on_d, osd_window_d, osd_pixel_d, use_clut;
  logic [1:0]    hsync_sr, vsync_sr; // two clocks of sync delay

  // OSD sits in the top two bits; blue tint outside osd pixels
  function automatic rtg_pkg::rgb_t osd_mix(input rtg_pkg::rgb_t c,
                                            input logic win, input logic pix);
    rtg_pkg::rgb_t o;
    o = c;
    if (win) begin
      o.r = {pix ? 2'b11 : 2'b00, c.r[CW-1:2]};
      o.g = {pix ? 2'b11 : 2'b00, c.g[CW-1:2]};
      o.b = {pix ? 2'b11 : 2'b10, c.b[CW-1:2]};
    end
    return o;
  endfunction

  // high byte first, then the low byte
  assign clut_idx = clut_sel_d ? rtg_data[`RTG_CLUT_AW-1:0]
                               : rtg_data[`RTG_WORD_W-1 -: `RTG_CLUT_AW];

  always_comb begin
    hc_rgb.r = {rtg_data[14:10], rtg_data[14:12]};  // 5 -> 8 bits
    hc_rgb.g = {rtg_data[9:5],   rtg_data[9:7]};
    hc_rgb.b = {rtg_data[4:0],   rtg_data[4:2]};
    rtg_on   = mode.ena && !rtg_blank;
    use_clut = mode.ena && mode.clut;                // two clock path
    src_now  = rtg_on ? hc_rgb : chip_rgb;
    src_clut = rtg_on_d ? clut_rgb : chip_rgb_d;
    out_nxt  = use_clut ? osd_mix(src_clut, osd_window_d, osd_pixel_d)
                        : osd_mix(src_now, osd_window, osd_pixel);
  end

  //////////////////////////////////////////////////////////////////////
  // alignment stage and output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    chip_rgb_d <= chip_rgb;  // waits for the CLUT read
  end

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      rtg_on_d     <= 1'b0;
      osd_window_d <= 1'b0;
      osd_pixel_d  <= 1'b0;
      hsync_sr     <= '0;
      vsync_sr     <= '0;
      vid_rgb      <= '0;
    end else begin
      rtg_on_d     <= rtg_on;
      osd_window_d <= osd_window;
      osd_pixel_d  <= osd_pixel;
      hsync_sr     <= {hsync_sr[0], chip_hsync};
      vsync_sr     <= {vsync_sr[0], chip_vsync};
      vid_rgb      <= out_nxt;
    end
  end

  assign vid_hsync = hsync_sr[1];
  assign vid_vsync = vsync_sr[1];

endmodule

// File: rtl/rtg_pkg.sv
/*
  Types shared by the RTG display blocks and the testbench.
  Refer to them as rtg_pkg::name.
*/
`include "rtg_defines.svh"

package rtg_pkg;

  // one 24-bit colour
  typedef struct packed {
    logic [`RTG_COLOR_W-1:0] r;
    logic [`RTG_COLOR_W-1:0] g;
    logic [`RTG_COLOR_W-1:0] b;
  } rgb_t;

  // mode register, msb first as written on cfg_wdata
  typedef struct packed {
    logic                     ena;        // RTG screen on
    logic                     clut;       // 8-bit indexed instead of RGB555
    logic                     ext;        // one extra fetch at blank start
    logic [`RTG_PWIDTH_W-1:0] pixelwidth; // clocks per fetch - 1
    logic [`RTG_VBEND_W-1:0]  vbend;      // lines to hide after vblank
  } rtg_mode_t;

endpackage

// File: rtl/rtg_video_top.sv
/*
  RTG display path top level. Connects config registers, colour
  table, blank generator, fetch timing and the output pixel path.
*/
`timescale 1ns/1ps
`include "rtg_defines.svh"

module rtg_video_top (
  input  logic                   clk_114,
  input  logic                   arst_n,
  // configuration write
  input  logic                   cfg_we,
  input  logic [`RTG_CFG_AW-1:0] cfg_addr,
  input  logic [23:0]            cfg_wdata,
  // chipset video
  input  rtg_pkg::rgb_t          chip_rgb,
  input  logic                   chip_hsync,
  input  logic                   chip_vsync,
  input  logic                   hblank,
  input  logic                   vblank,
  // RTG word, valid the cycle after fetch_req
  input  logic [`RTG_WORD_W-1:0] rtg_data,
  // OSD
  input  logic                   osd_window,
  input  logic                   osd_pixel,
  // outputs
  output logic                   fetch_req,
  output rtg_pkg::rgb_t          vid_rgb,
  output logic                   vid_hsync,
  output logic                   vid_vsync
);

  rtg_pkg::rtg_mode_t      mode;
  logic                    clut_we;
  logic [`RTG_CLUT_AW-1:0] clut_waddr, clut_idx;
  rtg_pkg::rgb_t           clut_wdata, clut_rgb;
  logic                    rtg_blank, rtg_blank_d, clut_sel_d;

  rtg_config_regs cfg_i (
    .clk_114, .arst_n, .cfg_we, .cfg_addr, .cfg_wdata,
    .mode, .clut_we, .clut_waddr, .clut_wdata
  );

  rtg_clut_ram clut_i (
    .clk_114, .clut_we, .clut_waddr, .clut_wdata, .clut_idx, .clut_rgb
  );

  rtg_blank_gen blank_i (
    .clk_114, .arst_n, .vblank, .hblank, .chip_hsync,
    .vbend (mode.vbend), .rtg_blank, .rtg_blank_d
  );

  rtg_fetch_timing fetch_i (
    .clk_114, .arst_n, .mode, .rtg_blank, .rtg_blank_d, .fetch_req, .clut_sel_d
  );

  rtg_pixel_out pix_i (
    .clk_114, .arst_n, .mode, .rtg_blank, .clut_sel_d, .rtg_data, .chip_rgb,
    .chip_hsync, .chip_vsync, .osd_window, .osd_pixel, .clut_idx, .clut_rgb,
    .vid_rgb, .vid_hsync, .vid_vsync
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the RTG video testbench with Verilator, then check the log.
rm -f sim.log && \
  verilator --binary --assert -j 0 --top-module tb_rtg_video -f all.f -o tb_rtg_video && \
  ./obj_dir/tb_rtg_video +verilator+error+limit+1000 > sim.log 2>&1
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" || \
  { echo "simulation failed"; exit 1; }

// File: sim/rtg_video_checker.sv
/*
  Reference model of the RTG display path. Samples the DUT ports on the
  falling clock edge, predicts fetch, colour and sync, counts mismatches.
*/
`timescale 1ns/1ps
`include "rtg_defines.svh"

module rtg_video_checker (
  input  logic                   clk_114,
  input  logic                   arst_n,
  input  logic                   cfg_we,
  input  logic [`RTG_CFG_AW-1:0] cfg_addr,
  input  logic [23:0]            cfg_wdata,
  input  rtg_pkg::rgb_t          chip_rgb,
  input  logic                   chip_hsync,
  input  logic                   chip_vsync,
  input  logic                   hblank,
  input  logic                   vblank,
  input  logic [`RTG_WORD_W-1:0] rtg_data,
  input  logic                   osd_window,
  input  logic                   osd_pixel,
  input  logic                   fetch_req,
  input  rtg_pkg::rgb_t          vid_rgb,
  input  logic                   vid_hsync,
  input  logic                   vid_vsync,
  output int                     err_cnt
);

  rtg_pkg::rtg_mode_t m;                         // modelled mode register
  rtg_pkg::rgb_t      tbl [1 << `RTG_CLUT_AW];   // modelled colour table
  rtg_pkg::rgb_t      exp_rgb, clut_q, chip_q;
  logic [`RTG_PWIDTH_W-1:0] pcnt;                // clocks since last word
  logic [`RTG_VBEND_W-1:0]  vcnt;                // lines since vblank
  logic vhide, blank_q, hs_q, sel, sel_d, on_q, win_q, pix_q;
  logic [1:0] hs_sr, vs_sr;                      // two clock sync delay
  int errs = 0;

  assign err_cnt = errs;

  // two OSD bits on top of each channel
  function automatic rtg_pkg::rgb_t overlay(input rtg_pkg::rgb_t c, input logic win,
                                            input logic pix);
    rtg_pkg::rgb_t o;
    o = c;
    if (win) begin
      o.r = {pix, pix, c.r[7:2]};
      o.g = {pix, pix, c.g[7:2]};
      o.b = {1'b1, pix, c.b[7:2]};  // blue tint off the osd pixels
    end
    return o;
  endfunction

  function automatic rtg_pkg::rgb_t expand555(input logic [15:0] d);
    rtg_pkg::rgb_t o;
    o.r = {d[14:10], d[14:12]};
    o.g = {d[9:5], d[9:7]};
    o.b = {d[4:0], d[4:2]};
    return o;
  endfunction

  task automatic compare_value(input string name, input logic [23:0] got,
                               input logic [23:0] exp);
    if (got !== exp) begin
      errs++;
      $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // one model step per clock
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_114) begin : model
    logic                    blank, fetch_exp, on_now;
    logic [`RTG_CLUT_AW-1:0] idx;
    if (!arst_n) begin
      m       = '0;
      vhide   = 1'b1;
      vcnt    = '0;
      blank_q = 1'b1;
      {hs_q, sel, sel_d, on_q, win_q, pix_q} = '0;
      {pcnt, hs_sr, vs_sr} = '0;
      {exp_rgb, clut_q, chip_q} = '0;
    end else begin
      blank     = vhide | hblank;
      fetch_exp = m.ena && (!blank || (!blank_q && m.ext)) && (pcnt == m.pixelwidth);
      compare_value("fetch_req", 24'(fetch_req), 24'(fetch_exp));
      compare_value("vid_rgb", vid_rgb, exp_rgb);
      compare_value("vid_hsync", 24'(vid_hsync), 24'(hs_sr[1]));
      compare_value("vid_vsync", 24'(vid_vsync), 24'(vs_sr[1]));
      on_now = m.ena && !blank;
      idx    = sel_d ? rtg_data[7:0] : rtg_data[15:8];  // high byte first
      if (m.ena && m.clut) begin
        exp_rgb = overlay(on_q ? clut_q : chip_q, win_q, pix_q);  // two clocks
      end else begin
        exp_rgb = overlay(on_now ? expand555(rtg_data) : chip_rgb, osd_window, osd_pixel);
      end
      clut_q = tbl[idx];       // read before this clock's write
      chip_q = chip_rgb;
      on_q   = on_now;
      win_q  = osd_window;
      pix_q  = osd_pixel;
      hs_sr  = {hs_sr[0], chip_hsync};
      vs_sr  = {vs_sr[0], chip_vsync};
      sel_d  = sel;
      if (blank || fetch_exp) begin
        pcnt = '0;
        sel  = 1'b0;
      end else begin
        if (pcnt == (m.pixelwidth >> 1)) sel = 1'b1;  // halfway, low byte next
        pcnt = pcnt + 4'd1;
      end
      if (vblank) begin
        vhide = 1'b1;
        vcnt  = '0;
      end else if (vcnt == m.vbend) begin
        vhide = 1'b0;
      end else if (chip_hsync && !hs_q) begin
        vcnt = vcnt + 7'd1;
      end
      hs_q    = chip_hsync;
      blank_q = blank;
      if (cfg_we && cfg_addr == `RTG_ADDR_MODE) begin
        m = rtg_pkg::rtg_mode_t'(cfg_wdata[$bits(rtg_pkg::rtg_mode_t)-1:0]);
      end else if (cfg_we && cfg_addr >= `RTG_CLUT_BASE) begin
        tbl[cfg_addr[`RTG_CLUT_AW-1:0]] = rtg_pkg::rgb_t'(cfg_wdata);
      end
    end
  end

endmodule

// File: sim/rtg_video_properties.sv
/*
  Concurrent checks on the fetch and blank timing, bound into the
  fetch timing and blank generator blocks. FETCH_SIDE picks the set
  for each binding; fail_cnt is read by the testbench.
*/
`timescale 1ns/1ps
`include "rtg_defines.svh"

module rtg_video_properties #(
  parameter bit FETCH_SIDE = 1'b1  // fetch timing set, else blank set
) (
  input logic                     clk_114,
  input logic                     arst_n,
  input logic                     fetch_req,
  input logic [`RTG_PWIDTH_W-1:0] pixelwidth,
  input logic                     clut_sel_d,
  input logic                     rtg_blank,
  input logic [`RTG_VBEND_W-1:0]  line_cnt,
  input logic [`RTG_VBEND_W-1:0]  vbend
);

  int fail_cnt = 0;

  if (FETCH_SIDE) begin : g_fetch

    // one clock strobe, back to back only at one word per clock
    fetch_pulse: assert property (@(posedge clk_114) disable iff (!arst_n)
      fetch_req && (pixelwidth != '0) |=> !fetch_req)
      else begin
        $error("fetch_req stayed high for more than one clock");
        fail_cnt++;
      end

    // second clock of each word indexes its high byte
    high_byte_first: assert property (@(posedge clk_114) disable iff (!arst_n)
      $past(fetch_req, 2) |-> !clut_sel_d)
      else begin
        $error("CLUT byte select not back on the high byte after a fetch");
        fail_cnt++;
      end

  end else begin : g_blank

    // top of frame stays hidden until vbend lines have gone by
    lines_hidden: assert property (@(posedge clk_114) disable iff (!arst_n)
      (line_cnt != vbend) |-> rtg_blank)
      else begin
        $error("RTG picture shown before vbend lines after vblank");
        fail_cnt++;
      end

  end

endmodule

bind rtg_fetch_timing rtg_video_properties #(.FETCH_SIDE(1'b1)) fetch_props_i (
  .clk_114, .arst_n, .fetch_req, .pixelwidth (mode.pixelwidth), .clut_sel_d,
  .rtg_blank, .line_cnt ('0), .vbend ('0)
);

bind rtg_blank_gen rtg_video_properties #(.FETCH_SIDE(1'b0)) blank_props_i (
  .clk_114, .arst_n, .fetch_req (1'b0), .pixelwidth ('0), .clut_sel_d (1'b0),
  .rtg_blank, .line_cnt (vb_cnt), .vbend
);

// File: sim/tb_rtg_video.sv
/*
  Testbench for the RTG display path. Builds synthetic frames with random
  chipset colour, OSD and RTG words, then steps through display modes.
*/
`timescale 1ns/1ps
`include "rtg_defines.svh"

module tb_rtg_video;

  localparam logic [31:0] SEED = 32'h6bb7ff24;
  localparam int LINE_LEN      = 48;                      // clocks per line
  localparam int FRAME_LINES   = 16;
  localparam int NUM_MODES     = 12;                      // two frames each
  localparam int FRAME_TIMEOUT = 2 * LINE_LEN * FRAME_LINES;

  logic                   clk_114, arst_n, cfg_we;
  logic [`RTG_CFG_AW-1:0] cfg_addr;
  logic [23:0]            cfg_wdata;
  rtg_pkg::rgb_t          chip_rgb = '0;
  logic chip_hsync = 1'b0, chip_vsync = 1'b0, hblank = 1'b1, vblank = 1'b1;
  logic osd_window = 1'b0, osd_pixel = 1'b0;
  logic [`RTG_WORD_W-1:0] rtg_data = '0;
  logic                   fetch_req, vid_hsync, vid_vsync;
  rtg_pkg::rgb_t          vid_rgb;
  logic [31:0]            lcg_state = SEED;
  int hpos = 0, vpos = 0, chk_errors, timeouts = 0;

  rtg_video_top dut_i (
    .clk_114, .arst_n, .cfg_we, .cfg_addr, .cfg_wdata, .chip_rgb, .chip_hsync,
    .chip_vsync, .hblank, .vblank, .rtg_data, .osd_window, .osd_pixel,
    .fetch_req, .vid_rgb, .vid_hsync, .vid_vsync
  );

  rtg_video_checker chk_i (
    .clk_114, .arst_n, .cfg_we, .cfg_addr, .cfg_wdata, .chip_rgb, .chip_hsync,
    .chip_vsync, .hblank, .vblank, .rtg_data, .osd_window, .osd_pixel,
    .fetch_req, .vid_rgb, .vid_hsync, .vid_vsync, .err_cnt (chk_errors)
  );

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // random mode, first entries pinned for coverage
  function automatic rtg_pkg::rtg_mode_t pick_mode(input int idx, input logic [31:0] r);
    rtg_pkg::rtg_mode_t m;
    m       = rtg_pkg::rtg_mode_t'(r[31:18]);
    m.ena   = (idx != 0);                  // first mode leaves RTG off
    m.vbend = {4'd0, r[20:18]};            // well inside the frame
    if (idx == 1) begin
      m.clut       = 1'b0;
      m.ext        = 1'b0;
      m.pixelwidth = 4'd12;                // count hits pw on first hblank clock
    end
    if (idx == 2) begin
      m.clut       = 1'b1;
      m.ext        = 1'b1;
      m.pixelwidth = 4'd2;                 // same line fit, so ext fetches
    end
    return m;
  endfunction

  task automatic write_cfg(input logic [`RTG_CFG_AW-1:0] addr, input logic [23:0] data);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk_114);
    cfg_we    <= 1'b0;
  endtask

  // vblank rising edge, low seen first
  task automatic wait_frame_start(output logic ok);
    logic seen_low;
    seen_low = 1'b0;
    ok       = 1'b0;
    for (int n = 0; n < FRAME_TIMEOUT && !ok; n++) begin
      @(posedge clk_114);
      if (!vblank) seen_low = 1'b1;
      else if (seen_low) ok = 1'b1;
    end
    if (!ok) begin
      timeouts++;
      $display("timeout: no frame start within %0d clocks", FRAME_TIMEOUT);
    end
  endtask

  initial begin
    clk_114 = 1'b0;
    forever #5 clk_114 = ~clk_114;
  end

  //////////////////////////////////////////////////////////////////////
  // synthetic video timing and random data
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_114) begin : stimulus
    logic [31:0] r1, r2;
    r1 = lcg(lcg_state);
    r2 = lcg(r1);
    lcg_state  <= r2;
    hpos       <= (hpos == LINE_LEN - 1) ? 0 : hpos + 1;
    if (hpos == LINE_LEN - 1) vpos <= (vpos == FRAME_LINES - 1) ? 0 : vpos + 1;
    hblank     <= (hpos < 10);
    chip_hsync <= (hpos >= 2) && (hpos < 6);   // inside hblank
    vblank     <= (vpos < 2);
    chip_vsync <= (vpos == 0);
    chip_rgb   <= rtg_pkg::rgb_t'(r1[31:8]);
    osd_window <= (r1[7:6] == 2'b11);          // about a quarter of clocks
    osd_pixel  <= r1[5];
    if (fetch_req) rtg_data <= r2[31:16];      // next word the clock after
  end

  initial begin : main_seq
    logic ok;
    int   assert_fails;
    ok        = 1'b1;
    arst_n    = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    repeat (4) @(posedge clk_114);
    arst_n <= 1'b1;
    for (int i = 0; i < (1 << `RTG_CLUT_AW); i++) begin
      write_cfg(`RTG_CLUT_BASE + 9'(i), lcg_state[31:8]);  // fill whole table
    end
    for (int i = 0; i < NUM_MODES && ok; i++) begin
      wait_frame_start(ok);
      if (ok) write_cfg(`RTG_ADDR_MODE, {10'd0, pick_mode(i, lcg_state)});
      if (ok) wait_frame_start(ok);
    end
    repeat (4) @(posedge clk_114);
    assert_fails = dut_i.fetch_i.fetch_props_i.fail_cnt + dut_i.blank_i.blank_props_i.fail_cnt;
    $display("errors: checker %0d, assertions %0d, timeouts %0d",
             chk_errors, assert_fails, timeouts);
    if (ok && chk_errors == 0 && assert_fails == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
